/* design/decodePkg.sv */
`default_nettype none

package decodePkg;

  localparam int regCodeWidth = 4;
  localparam int dataWidth    = 16;

  // special register codes
  localparam logic [3:0] regIh   = 4'd8;
  localparam logic [3:0] regSp   = 4'd9;
  localparam logic [3:0] regRa   = 4'd10;
  localparam logic [3:0] regT    = 4'd11;
  localparam logic [3:0] regNone = 4'd15; // never written

  typedef enum logic [2:0] {
    jcIdle    = 3'd0,
    jcEqz     = 3'd1,
    jcNez     = 3'd2,
    jcTeqz    = 3'd3,
    jcTnez    = 3'd4,
    jcJumpReg = 3'd5,
    jcDirect  = 3'd6
  } jumpCtrl_e;

  // major opcodes, nop/eret/int fall through to the default decode
  localparam logic [4:0] opAddsp3  = 5'b00000;
  localparam logic [4:0] opB       = 5'b00010;
  localparam logic [4:0] opBeqz    = 5'b00100;
  localparam logic [4:0] opBnez    = 5'b00101;
  localparam logic [4:0] opShift   = 5'b00110; // sll, srl, sra
  localparam logic [4:0] opAddiu3  = 5'b01000;
  localparam logic [4:0] opAddiu   = 5'b01001;
  localparam logic [4:0] opSlti    = 5'b01010;
  localparam logic [4:0] opSltui   = 5'b01011;
  localparam logic [4:0] opSpGroup = 5'b01100; // addsp, bteqz, btnez, mtsp, sw_rs
  localparam logic [4:0] opLi      = 5'b01101;
  localparam logic [4:0] opCmpi    = 5'b01110;
  localparam logic [4:0] opMove    = 5'b01111;
  localparam logic [4:0] opLwSp    = 5'b10010;
  localparam logic [4:0] opLw      = 5'b10011;
  localparam logic [4:0] opSwSp    = 5'b11010;
  localparam logic [4:0] opSw      = 5'b11011;
  localparam logic [4:0] opAddu    = 5'b11100; // addu, subu
  localparam logic [4:0] opRrr     = 5'b11101;
  localparam logic [4:0] opMfih    = 5'b11110; // mfih, mtih

  // rx sub-codes of the sp group
  localparam logic [2:0] spBteqz = 3'b000;
  localparam logic [2:0] spBtnez = 3'b001;
  localparam logic [2:0] spSwRs  = 3'b010;
  localparam logic [2:0] spAddsp = 3'b011;
  localparam logic [2:0] spMtsp  = 3'b100;

  // low function bits of opRrr
  localparam logic [4:0] fnJump = 5'b00000; // jr, jrra, mfpc, jalr
  localparam logic [4:0] fnSlt  = 5'b00010;
  localparam logic [4:0] fnSltu = 5'b00011;
  localparam logic [4:0] fnSllv = 5'b00100;
  localparam logic [4:0] fnSrlv = 5'b00110;
  localparam logic [4:0] fnSrav = 5'b00111;
  localparam logic [4:0] fnCmp  = 5'b01010;
  localparam logic [4:0] fnNeg  = 5'b01011;
  localparam logic [4:0] fnAnd  = 5'b01100;
  localparam logic [4:0] fnOr   = 5'b01101;
  localparam logic [4:0] fnXor  = 5'b01110;
  localparam logic [4:0] fnNot  = 5'b01111;

  // ry sub-codes of the jump subgroup
  localparam logic [2:0] jsJr   = 3'b000;
  localparam logic [2:0] jsJrra = 3'b001;
  localparam logic [2:0] jsMfpc = 3'b010;
  localparam logic [2:0] jsJalr = 3'b110;

  typedef union packed {
    struct packed {
      logic [4:0] op;
      logic [2:0] rx;
      logic [2:0] ry;
      logic [2:0] rz;
      logic [1:0] func2;
    } rrr;
    struct packed {
      logic [4:0] op;
      logic [2:0] rx;
      logic [7:0] imm8;
    } ri;
  } instrWord_u;

endpackage

`default_nettype wire

/* design/instrDecoder.sv */
`default_nettype none

module instrDecoder (
  input  wire logic                                clk,
  input  wire logic                                rst,
  input  wire logic                                instrValid,
  input  wire decodePkg::instrWord_u               instr,
  input  wire logic [decodePkg::dataWidth-1:0]     pc,
  output logic [decodePkg::regCodeWidth-1:0]       regS,
  output logic [decodePkg::regCodeWidth-1:0]       regM,
  output logic [decodePkg::regCodeWidth-1:0]       regT,
  output decodePkg::jumpCtrl_e                     jumpCtrl,
  output logic [decodePkg::dataWidth-1:0]          branchOffset,
  output logic [decodePkg::dataWidth-1:0]          pcD,
  output logic                                     decValid
);

  import decodePkg::*;

  logic [regCodeWidth-1:0] rxCode, ryCode, rzCode;
  logic [4:0]              funcCode;
  logic [10:0]             longOff;
  logic [dataWidth-1:0]    shortExt, longExt;

  logic [regCodeWidth-1:0] nextS, nextM, nextT;
  jumpCtrl_e               nextJc;
  logic [dataWidth-1:0]    nextOffset;

  assign rxCode   = {1'b0, instr.rrr.rx};
  assign ryCode   = {1'b0, instr.rrr.ry};
  assign rzCode   = {1'b0, instr.rrr.rz};
  assign funcCode = {instr.rrr.rz, instr.rrr.func2};

  // b reads its offset across rx and imm8
  assign longOff  = {instr.ri.rx, instr.ri.imm8};
  assign shortExt = {{(dataWidth-8){instr.ri.imm8[7]}}, instr.ri.imm8};
  assign longExt  = {{(dataWidth-11){longOff[10]}}, longOff};

  always_comb
  begin
    nextS      = '0;
    nextM      = '0;
    nextT      = regNone; // unknown ops write nothing
    nextJc     = jcIdle;
    nextOffset = '0;
    if (instrValid)
    begin
      case (instr.rrr.op)
        opAddsp3:
        begin
          nextS = regSp;
          nextT = rxCode;
        end
        opB:
        begin
          nextJc     = jcDirect;
          nextOffset = longExt;
        end
        opBeqz, opBnez:
        begin
          nextS      = rxCode;
          nextJc     = (instr.rrr.op == opBeqz) ? jcEqz : jcNez;
          nextOffset = shortExt;
        end
        opShift, opMove:
        begin
          nextS = ryCode;
          nextT = rxCode;
        end
        opAddiu3:
        begin
          nextS = rxCode;
          nextT = ryCode;
        end
        opAddiu:
        begin
          nextS = rxCode;
          nextT = rxCode;
        end
        opSlti, opSltui, opCmpi:
          nextS = rxCode;            // result goes to T flag later
        opSpGroup:
          case (instr.ri.rx)
            spBteqz, spBtnez:
            begin
              nextJc     = (instr.ri.rx == spBteqz) ? jcTeqz : jcTnez;
              nextOffset = shortExt;
            end
            spSwRs:
            begin
              nextS = regRa;
              nextM = regSp;
            end
            spAddsp:
            begin
              nextS = regSp;
              nextT = regSp;
            end
            spMtsp:
            begin
              nextS = ryCode;
              nextT = regSp;
            end
            default: ;
          endcase
        opLi:
          nextT = rxCode;
        opLwSp:
        begin
          nextM = regSp;
          nextT = rxCode;
        end
        opLw:
        begin
          nextM = rxCode;
          nextT = ryCode;
        end
        opSwSp:
        begin
          nextS = rxCode;
          nextM = regSp;
        end
        opSw:
        begin
          nextS = ryCode;
          nextM = rxCode;
        end
        opAddu:
        begin
          nextS = rxCode;
          nextM = ryCode;
          nextT = rzCode;
        end
        opRrr:
          case (funcCode)
            fnJump:
              case (instr.rrr.ry)
                jsJr:
                begin
                  nextS  = rxCode;
                  nextJc = jcJumpReg;
                end
                jsJrra:
                begin
                  nextS  = regRa;
                  nextJc = jcJumpReg;
                end
                jsMfpc:
                  nextT = rxCode;
                jsJalr:
                begin
                  nextS  = rxCode;
                  nextT  = regRa;  // link register
                  nextJc = jcJumpReg;
                end
                default: ;
              endcase
            fnSlt, fnSltu:
            begin
              nextS = rxCode;
              nextM = ryCode;
            end
            fnSllv, fnSrlv, fnSrav:
            begin
              nextS = ryCode;
              nextM = rxCode;
              nextT = ryCode;
            end
            fnCmp:
            begin
              nextS = ryCode;
              nextM = rxCode;
            end
            fnNeg, fnNot:
            begin
              nextS = ryCode;
              nextT = rxCode;
            end
            fnAnd, fnOr, fnXor:
            begin
              nextS = ryCode;
              nextM = rxCode;
              nextT = rxCode;
            end
            default: ;
          endcase
        opMfih:
          if (instr.rrr.func2[0])
          begin
            nextS = rxCode;          // mtih
            nextT = regIh;
          end
          else
          begin
            nextS = regIh;           // mfih
            nextT = rxCode;
          end
        default: ;                   // nop, eret, int and unknown
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      regS     <= '0;
      regM     <= '0;
      regT     <= regNone;
      jumpCtrl <= jcIdle;
      decValid <= 1'b0;
    end
    else
    begin
      regS     <= nextS;
      regM     <= nextM;
      regT     <= nextT;
      jumpCtrl <= nextJc;
      decValid <= instrValid;
    end
  end

  always_ff @(posedge clk)
  begin
    branchOffset <= nextOffset;
    pcD          <= pc;
  end

endmodule

`default_nettype wire

/* design/registerFile.sv */
`default_nettype none

module registerFile (
  input  wire logic                                clk,
  input  wire logic                                rst,
  input  wire logic [decodePkg::regCodeWidth-1:0]  readAddrS,
  input  wire logic [decodePkg::regCodeWidth-1:0]  readAddrM,
  input  wire logic                                writeEnable,
  input  wire logic [decodePkg::regCodeWidth-1:0]  writeAddr,
  input  wire logic [decodePkg::dataWidth-1:0]     writeData,
  output logic [decodePkg::dataWidth-1:0]          valueS,
  output logic [decodePkg::dataWidth-1:0]          valueM,
  output logic [decodePkg::dataWidth-1:0]          tValue
);

  import decodePkg::*;

  localparam int depth = 2 ** regCodeWidth;

  logic [dataWidth-1:0] regs [depth];
  logic                 writeHit;

  assign writeHit = writeEnable && (writeAddr != regNone); // code 15 is read-only zero

  // same-cycle write wins over the stored word
  function automatic logic [dataWidth-1:0] readPort(input logic [regCodeWidth-1:0] addr);
    if (writeHit && (addr == writeAddr))
      return writeData;
    return regs[addr];
  endfunction

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      for (int i = 0; i < depth; i++)
        regs[i] <= '0;
    end
    else if (writeHit)
    begin
      regs[writeAddr] <= writeData;
    end
  end

  assign valueS = readPort(readAddrS);
  assign valueM = readPort(readAddrM);
  assign tValue = readPort(regT);   // T flag always visible

endmodule

`default_nettype wire

/* design/branchResolver.sv */
`default_nettype none

module branchResolver (
  input  wire logic                                clk,
  input  wire logic                                rst,
  input  wire logic                                decValid,
  input  wire decodePkg::jumpCtrl_e                jumpCtrl,
  input  wire logic [decodePkg::regCodeWidth-1:0]  regT,
  input  wire logic [decodePkg::dataWidth-1:0]     branchOffset,
  input  wire logic [decodePkg::dataWidth-1:0]     pcD,
  input  wire logic [decodePkg::dataWidth-1:0]     valueS,
  input  wire logic [decodePkg::dataWidth-1:0]     valueM,
  input  wire logic [decodePkg::dataWidth-1:0]     tValue,
  output logic                                     outValid,
  output logic                                     branchTaken,
  output logic [decodePkg::regCodeWidth-1:0]       destReg,
  output logic [decodePkg::dataWidth-1:0]          opS,
  output logic [decodePkg::dataWidth-1:0]          opM,
  output logic [decodePkg::dataWidth-1:0]          branchTarget
);

  import decodePkg::*;

  logic [dataWidth-1:0] seqPc;
  logic [dataWidth-1:0] relTarget;
  logic                 sZero, tZero;
  logic                 taken;
  logic [dataWidth-1:0] target;

  assign seqPc     = pcD + 16'd1;
  assign relTarget = seqPc + branchOffset;  // pc + 1 + offset
  assign sZero     = (valueS == '0);
  assign tZero     = (tValue == '0);

  always_comb
  begin
    case (jumpCtrl)
      jcEqz:     taken = sZero;
      jcNez:     taken = !sZero;
      jcTeqz:    taken = tZero;
      jcTnez:    taken = !tZero;
      jcDirect:  taken = 1'b1;
      jcJumpReg: taken = 1'b1;
      default:   taken = 1'b0;     // idle whenever decValid is low
    endcase
  end

  always_comb
  begin
    if (!taken)
      target = seqPc;
    else if (jumpCtrl == jcJumpReg)
      target = valueS;              // jr, jrra, jalr
    else
      target = relTarget;
  end

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      outValid    <= 1'b0;
      branchTaken <= 1'b0;
      destReg     <= regNone;
    end
    else
    begin
      outValid    <= decValid;
      branchTaken <= taken;
      destReg     <= regT;
    end
  end

  always_ff @(posedge clk)
  begin
    opS          <= valueS;
    opM          <= valueM;
    branchTarget <= target;
  end

endmodule

`default_nettype wire

/* design/decodeStage.sv */
`default_nettype none

module decodeStage (
  input  wire logic                                clk,
  input  wire logic                                rst,
  input  wire logic                                instrValid,
  input  wire logic [decodePkg::dataWidth-1:0]     instr,
  input  wire logic [decodePkg::dataWidth-1:0]     pc,
  input  wire logic                                writeEnable,
  input  wire logic [decodePkg::regCodeWidth-1:0]  writeAddr,
  input  wire logic [decodePkg::dataWidth-1:0]     writeData,
  output logic                                     outValid,
  output logic                                     branchTaken,
  output logic [decodePkg::regCodeWidth-1:0]       destReg,
  output logic [decodePkg::dataWidth-1:0]          opS,
  output logic [decodePkg::dataWidth-1:0]          opM,
  output logic [decodePkg::dataWidth-1:0]          branchTarget
);

  import decodePkg::*;

  logic [regCodeWidth-1:0] regS, regM, regT;
  jumpCtrl_e               jumpCtrl;
  logic [dataWidth-1:0]    branchOffset;
  logic [dataWidth-1:0]    pcD;
  logic                    decValid;
  logic [dataWidth-1:0]    valueS, valueM, tValue;

  instrDecoder decoder (
    .clk          (clk),
    .rst          (rst),
    .instrValid   (instrValid),
    .instr        (instr),          // viewed as instrWord_u inside
    .pc           (pc),
    .regS         (regS),
    .regM         (regM),
    .regT         (regT),
    .jumpCtrl     (jumpCtrl),
    .branchOffset (branchOffset),
    .pcD          (pcD),
    .decValid     (decValid)
  );

  registerFile regFile (
    .clk         (clk),
    .rst         (rst),
    .readAddrS   (regS),
    .readAddrM   (regM),
    .writeEnable (writeEnable),
    .writeAddr   (writeAddr),
    .writeData   (writeData),
    .valueS      (valueS),
    .valueM      (valueM),
    .tValue      (tValue)
  );

  branchResolver resolver (
    .clk          (clk),
    .rst          (rst),
    .decValid     (decValid),
    .jumpCtrl     (jumpCtrl),
    .regT         (regT),
    .branchOffset (branchOffset),
    .pcD          (pcD),
    .valueS       (valueS),
    .valueM       (valueM),
    .tValue       (tValue),
    .outValid     (outValid),
    .branchTaken  (branchTaken),
    .destReg      (destReg),
    .opS          (opS),
    .opM          (opM),
    .branchTarget (branchTarget)
  );

endmodule

`default_nettype wire

/* verification/clockGen.sv */
`default_nettype none

module clockGen (
  output logic clk
);

  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

endmodule

`default_nettype wire

/* verification/decodeStage_properties.sv */
`default_nettype none

module decodeStage_properties (
  input wire logic                             clk,
  input wire logic                             rst,
  input wire logic                             instrValid,
  input wire logic                             outValid,
  input wire logic                             branchTaken,
  input wire logic [decodePkg::dataWidth-1:0]  pcD,
  input wire logic [decodePkg::dataWidth-1:0]  branchTarget
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned failCount = 0; // read by the testbench at the end

  resetQuiet: assert property (@(posedge clk) !rst |-> !outValid)
  else
  begin
    failCount++;
    $error("outValid high while rst is asserted");
  end

  takenNeedsValid: assert property (@(posedge clk) disable iff (!rst)
    !outValid |-> !branchTaken)
  else
  begin
    failCount++;
    $error("branchTaken high without outValid");
  end

  // pcD held the instruction one edge before the output register
  fallThrough: assert property (@(posedge clk) disable iff (!rst)
    (outValid && !branchTaken) |-> (branchTarget == $past(pcD) + 16'd1))
  else
  begin
    failCount++;
    $error("not-taken branchTarget differs from pc plus 1");
  end

  validLatency: assert property (@(posedge clk) disable iff (!rst)
    outValid |-> $past(instrValid, 2))
  else
  begin
    failCount++;
    $error("outValid without instrValid two cycles earlier");
  end

endmodule

`default_nettype wire

/* verification/decodeStageTb.sv */
`default_nettype none

module decodeStageTb;

  timeunit 1ns;
  timeprecision 1ps;

  import decodePkg::*;

  localparam int recordWords = 9;   // columns per stimulus record
  localparam int maxRecords  = 64;
  localparam int drainLimit  = 10;

  typedef struct packed {
    logic [15:0] instr;
    logic [15:0] pc;
    logic [3:0]  srcS;
    logic [3:0]  srcM;
    logic [3:0]  dest;
    logic [2:0]  jc;
    int          issue;   // cycle the instruction was driven
  } pending_t;

  logic        clk;
  logic        rst;
  logic        instrValid;
  logic [15:0] instr;
  logic [15:0] pc;
  logic        writeEnable;
  logic [3:0]  writeAddr;
  logic [15:0] writeData;
  logic        outValid;
  logic        branchTaken;
  logic [3:0]  destReg;
  logic [15:0] opS;
  logic [15:0] opM;
  logic [15:0] branchTarget;

  logic [15:0] stimMem [maxRecords*recordWords];
  logic [15:0] shadow [16];   // register contents after every applied write
  pending_t    pendQ [$];
  int          cycle;

  clockGen clkGen (
    .clk (clk)
  );

  decodeStage uut (
    .clk          (clk),
    .rst          (rst),
    .instrValid   (instrValid),
    .instr        (instr),
    .pc           (pc),
    .writeEnable  (writeEnable),
    .writeAddr    (writeAddr),
    .writeData    (writeData),
    .outValid     (outValid),
    .branchTaken  (branchTaken),
    .destReg      (destReg),
    .opS          (opS),
    .opM          (opM),
    .branchTarget (branchTarget)
  );

  bind decodeStage decodeStage_properties props (
    .clk          (clk),
    .rst          (rst),
    .instrValid   (instrValid),
    .outValid     (outValid),
    .branchTaken  (branchTaken),
    .pcD          (pcD),
    .branchTarget (branchTarget)
  );

  task automatic failCheck(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic abortRun(input string msg);
    $display("Run aborted at %0t ns because %s", $time, msg);
    $display("Test failed");
    $fatal(1, "stopped");
  endtask

  // beqz family uses imm8, b uses the 11-bit field
  function automatic logic [15:0] branchOffsetOf(input logic [15:0] word, input logic [2:0] jc);
    logic [15:0] off;
    off = 16'd0;
    if (jc == jcEqz || jc == jcNez || jc == jcTeqz || jc == jcTnez)
      off = {{8{word[7]}}, word[7:0]};
    else if (jc == jcDirect)
      off = {{5{word[10]}}, word[10:0]};
    return off;
  endfunction

  task automatic checkOutputs();
    pending_t    entry;
    logic [15:0] valS;
    logic [15:0] valM;
    logic [15:0] tVal;
    logic [15:0] seqPc;
    logic [15:0] expTarget;
    logic        expTaken;
    if (pendQ.size() != 0 && pendQ[0].issue == cycle - 2)
    begin
      entry = pendQ.pop_front();
      valS  = shadow[entry.srcS];
      valM  = shadow[entry.srcM];
      tVal  = shadow[11];                // T flag register
      case (entry.jc)
        jcEqz:     expTaken = (valS == 16'd0);
        jcNez:     expTaken = (valS != 16'd0);
        jcTeqz:    expTaken = (tVal == 16'd0);
        jcTnez:    expTaken = (tVal != 16'd0);
        jcDirect:  expTaken = 1'b1;
        jcJumpReg: expTaken = 1'b1;
        default:   expTaken = 1'b0;
      endcase
      seqPc = entry.pc + 16'd1;
      if (!expTaken)
        expTarget = seqPc;
      else if (entry.jc == jcJumpReg)
        expTarget = valS;
      else
        expTarget = seqPc + branchOffsetOf(entry.instr, entry.jc);
      assert (outValid === 1'b1)
        else failCheck($sformatf("no outValid for instr %h at pc %h", entry.instr, entry.pc));
      assert (destReg === entry.dest)
        else failCheck($sformatf("pc %h destReg %h, expected %h", entry.pc, destReg, entry.dest));
      assert (opS === valS)
        else failCheck($sformatf("pc %h opS %h, expected %h", entry.pc, opS, valS));
      assert (opM === valM)
        else failCheck($sformatf("pc %h opM %h, expected %h", entry.pc, opM, valM));
      assert (branchTaken === expTaken)
        else failCheck($sformatf("pc %h branchTaken %b, expected %b", entry.pc, branchTaken,
                                 expTaken));
      assert (branchTarget === expTarget)
        else failCheck($sformatf("pc %h branchTarget %h, expected %h", entry.pc, branchTarget,
                                 expTarget));
    end
    else
    begin
      assert (outValid === 1'b0)
        else failCheck("outValid pulse with no instruction due");
      assert (branchTaken === 1'b0)
        else failCheck("branchTaken high with no instruction due");
    end
  endtask

  // drive one record, the DUT samples it at the next rising edge
  task automatic applyRecord(input int base, input logic [3:0] ctl);
    pending_t entry;
    writeEnable = ctl[0];
    writeAddr   = stimMem[base+1][3:0];
    writeData   = stimMem[base+2];
    instrValid  = ctl[1];
    instr       = stimMem[base+3];
    pc          = stimMem[base+4];
    if (ctl[0] && stimMem[base+1][3:0] != regNone)
      shadow[stimMem[base+1][3:0]] = stimMem[base+2];
    if (ctl[1])
    begin
      entry.instr = stimMem[base+3];
      entry.pc    = stimMem[base+4];
      entry.srcS  = stimMem[base+5][3:0];
      entry.srcM  = stimMem[base+6][3:0];
      entry.dest  = stimMem[base+7][3:0];
      entry.jc    = stimMem[base+8][2:0];
      entry.issue = cycle;
      pendQ.push_back(entry);
    end
  endtask

  initial
  begin
    int         base;
    int         recordCount;
    int         drainCycles;
    logic [3:0] ctl;
    bit         done;
    rst         = 1'b0;
    instrValid  = 1'b0;
    instr       = 16'd0;
    pc          = 16'd0;
    writeEnable = 1'b0;
    writeAddr   = 4'd0;
    writeData   = 16'd0;
    cycle       = 0;
    for (int i = 0; i < 16; i++)
      shadow[i] = 16'd0;
    $readmemh("verification/decode_stimulus.txt", stimMem);

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    assert (outValid === 1'b0 && branchTaken === 1'b0)
      else failCheck("outValid or branchTaken high after reset");
    assert (destReg === regNone)
      else failCheck($sformatf("destReg %h after reset, expected f", destReg));

    recordCount = 0;
    done        = 1'b0;
    while (!done)
    begin
      if (recordCount == maxRecords)
        abortRun("the stimulus file has no end record");
      base = recordCount * recordWords;
      ctl  = stimMem[base][3:0];
      if (ctl == 4'hf)
        done = 1'b1;
      else
      begin
        @(negedge clk);
        checkOutputs();
        applyRecord(base, ctl);
        cycle++;
        recordCount++;
      end
    end

    drainCycles = 0;
    while (pendQ.size() != 0)
    begin
      if (drainCycles == drainLimit)
        abortRun("outValid never came for the last instructions");
      @(negedge clk);
      checkOutputs();
      writeEnable = 1'b0;
      instrValid  = 1'b0;
      cycle++;
      drainCycles++;
    end
    repeat (2)
    begin
      @(negedge clk);
      checkOutputs();                    // no stray pulses once idle
      cycle++;
    end

    if (uut.props.failCount == 0)
    begin
      $display("Test completed successfully");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/decode_stimulus.txt */
// ctl waddr wdata instr pc srcS srcM dest jc (hex); ctl 1 write, 2 instruction, 3 both, f end
// jc 0 idle, 1 eqz, 2 nez, 3 teqz, 4 tnez, 5 jump register, 6 direct
1 0 1000 0000 0000 0 0 f 0
1 1 0011 0000 0000 0 0 f 0
1 2 0022 0000 0000 0 0 f 0
1 4 0044 0000 0000 0 0 f 0
3 6 0066 e151 0100 1 2 4 0 // addu
3 7 0077 9ba2 0101 0 3 5 0 // lw
3 8 8888 dac1 0102 6 2 f 0 // sw
3 9 9999 7f20 0103 1 0 7 0 // move
3 a 0a0a ec6c 0104 3 4 4 0 // and
2 0 0000 f200 0105 8 0 2 0 // mfih
2 0 0000 f601 0106 6 0 8 0 // mtih
2 0 0000 6305 0107 9 0 9 0 // addsp
2 0 0000 6203 0108 a 9 f 0 // sw_rs
2 0 0000 0504 0109 9 0 5 0 // addsp3
2 0 0000 2510 0200 5 0 f 1 // beqz taken
2 0 0000 29fe 0201 1 0 f 2 // bnez taken backwards
2 0 0000 2220 0202 2 0 f 1 // beqz not taken
2 0 0000 6008 0203 0 0 f 3 // bteqz
2 0 0000 6180 0204 0 0 f 4 // btnez, sees T written next cycle
3 b 0001 6180 0205 0 0 f 4
2 0 0000 17f0 0300 0 0 f 6 // b negative offset
2 0 0000 1123 0301 0 0 f 6 // b positive offset
2 0 0000 ec00 0302 4 0 f 5 // jr, r4 rewritten next cycle
3 4 abcd e820 0303 a 0 f 5 // jrra
2 0 0000 eec0 0304 6 0 a 5 // jalr
3 1 5555 e151 0305 1 2 4 0
3 1 7777 e151 0306 1 2 4 0 // back to back with bypass
3 f dead 0800 0307 0 0 f 0 // nop, write to 15 dropped
2 0 0000 b800 0308 0 0 f 0 // unknown opcode
f 0 0000 0000 0000 0 0 f 0

/* verilog.f */
design/decodePkg.sv
design/instrDecoder.sv
design/registerFile.sv
design/branchResolver.sv
design/decodeStage.sv
verification/clockGen.sv
verification/decodeStage_properties.sv
verification/decodeStageTb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := decodeStageTb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
SIM_ARGS  := +verilator+error+limit+100
LOG       := sim.log
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
